// ==== rtl/fetch_pkg.sv ====
////////////////////////////////////////
// fetch predictor package
// pc and branch types, table sizes and
// the packed structs passed between the
// fetch unit and its predictor tables
////////////////////////////////////////

`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // sizes

    localparam int PC_W        = 32;
    localparam int BTB_IDX_W   = 6;
    localparam int BTB_TAG_W   = 24;
    localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
    localparam int PHT_IDX_W   = 8;
    localparam int PHT_ENTRIES = 1 << PHT_IDX_W;
    localparam int GHR_W       = 8;
    localparam int RAS_DEPTH   = 8;
    localparam int RAS_PTR_W   = 3;

    ////////////////////////////////////////
    // basic types

    typedef logic [PC_W-1:0]      pc_t;
    typedef logic [GHR_W-1:0]     ghr_t;
    typedef logic [RAS_PTR_W-1:0] ras_ptr_t;
    // one extra bit so a full stack is representable
    typedef logic [RAS_PTR_W:0]   ras_cnt_t;

    typedef enum logic [1:0] {
        BR_COND = 2'b00,
        BR_JUMP = 2'b01,
        BR_CALL = 2'b10,
        BR_RET  = 2'b11
    } br_type_t;

    ////////////////////////////////////////
    // structs

    // stored btb entry, a return ignores its target
    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        br_type_t             br_type;
        pc_t                  target;
    } btb_entry_t;

    // training packet from execute
    typedef struct packed {
        pc_t      pc;
        pc_t      target;
        br_type_t br_type;
        logic     taken;
    } branch_update_t;

    // one emitted fetch
    typedef struct packed {
        pc_t  pc;
        pc_t  next_pc;
        logic pred_taken;
    } fetch_out_t;

endpackage

`default_nettype wire

// ==== rtl/btb.sv ====
////////////////////////////////////////
// branch target buffer
// direct mapped, 64 entries, registered
// read with tag compare in the next cycle
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module btb
    import fetch_pkg::*;
(
    input  logic           CLK,
    input  logic           reset,

    // read from REQ
    input  logic           read_valid,
    input  pc_t            read_pc,

    // response in RESP
    output logic           hit,
    output br_type_t       hit_type,
    output pc_t            hit_target,

    // training from execute
    input  logic           update_valid,
    input  branch_update_t update
);

    ////////////////////////////////////////
    // storage and read latch

    btb_entry_t entries [BTB_ENTRIES];

    logic                 read_valid_q;
    btb_entry_t           read_entry_q;
    logic [BTB_TAG_W-1:0] read_tag_q;

    // index pc[7:2], tag pc[31:8]
    logic [BTB_IDX_W-1:0] read_idx;
    logic [BTB_IDX_W-1:0] upd_idx;
    logic                 upd_write;
    btb_entry_t           upd_entry;

    assign read_idx = read_pc[BTB_IDX_W+1:2];
    assign upd_idx  = update.pc[BTB_IDX_W+1:2];

    // not-taken cond branches never allocate
    assign upd_write = update_valid && (update.taken || update.br_type != BR_COND);

    always_comb begin
        upd_entry         = '0;
        upd_entry.valid   = 1'b1;
        upd_entry.tag     = update.pc[PC_W-1:BTB_IDX_W+2];
        upd_entry.br_type = update.br_type;
        upd_entry.target  = update.target;
    end

    ////////////////////////////////////////
    // table write

    always_ff @(posedge CLK) begin
        if (reset) begin
            // only the valid bits need clearing
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (upd_write) begin
            entries[upd_idx] <= upd_entry;
        end
    end

    // read sees the pre-update contents
    always_ff @(posedge CLK) begin
        if (reset) begin
            read_valid_q <= 1'b0;
        end else begin
            read_valid_q <= read_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (read_valid) begin
            read_entry_q <= entries[read_idx];
            read_tag_q   <= read_pc[PC_W-1:BTB_IDX_W+2];
        end
    end

    // hit check in RESP
    assign hit        = read_valid_q && read_entry_q.valid && (read_entry_q.tag == read_tag_q);
    assign hit_type   = read_entry_q.br_type;
    assign hit_target = read_entry_q.target;

    // a hit must come from a read one cycle earlier
    a_hit_needs_read: assert property (@(posedge CLK) disable iff (reset)
        !read_valid |=> !hit);

endmodule

`default_nettype wire

// ==== rtl/pht.sv ====
////////////////////////////////////////
// gshare pattern history table
// 256 two-bit counters indexed by pc xor
// global history, history shifts on update
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pht
    import fetch_pkg::*;
(
    input  logic           CLK,
    input  logic           reset,

    // read from REQ
    input  logic           read_valid,
    input  pc_t            read_pc,

    // prediction in RESP
    output logic           taken,

    // training from execute
    input  logic           update_valid,
    input  branch_update_t update
);

    ////////////////////////////////////////
    // counters and history

    logic [PHT_ENTRIES-1:0][1:0] ctr_q;
    ghr_t                        ghr_q;

    logic [PHT_IDX_W-1:0] read_idx;
    logic [PHT_IDX_W-1:0] upd_idx;
    logic [1:0]           upd_ctr;
    logic                 upd_cond;

    // gshare index, pc[9:2] xor history
    assign read_idx = read_pc[PHT_IDX_W+1:2] ^ ghr_q;
    assign upd_idx  = update.pc[PHT_IDX_W+1:2] ^ ghr_q;
    assign upd_ctr  = ctr_q[upd_idx];

    // only conditional branches train
    assign upd_cond = update_valid && (update.br_type == BR_COND);

    always_ff @(posedge CLK) begin
        if (reset) begin
            // weakly not taken everywhere
            ctr_q <= {PHT_ENTRIES{2'b01}};
            ghr_q <= '0;
        end else if (upd_cond) begin
            // saturate at 11 and 00
            if (update.taken && upd_ctr != 2'b11) begin
                ctr_q[upd_idx] <= upd_ctr + 2'd1;
            end else if (!update.taken && upd_ctr != 2'b00) begin
                ctr_q[upd_idx] <= upd_ctr - 2'd1;
            end
            // newest outcome enters at bit 0
            ghr_q <= {ghr_q[GHR_W-2:0], update.taken};
        end
    end

    ////////////////////////////////////////
    // read port

    // upper counter bit means 2 or more
    always_ff @(posedge CLK) begin
        if (read_valid) begin
            taken <= ctr_q[read_idx][1];
        end
    end

    // table only moves on a training packet
    a_ctr_stable: assert property (@(posedge CLK) disable iff (reset)
        !update_valid |=> $stable(ctr_q));

endmodule

`default_nettype wire

// ==== rtl/ras.sv ====
////////////////////////////////////////
// return address stack
// 8-entry circular stack, newest push
// overwrites the oldest when full
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ras
    import fetch_pkg::*;
(
    input  logic CLK,
    input  logic reset,

    // from RESP
    input  logic push_valid,
    input  pc_t  push_pc,
    input  logic pop_valid,

    // combinational top of stack
    output pc_t  top_pc,
    output logic empty
);

    ////////////////////////////////////////
    // state

    pc_t      stack [RAS_DEPTH];
    ras_ptr_t top_q;
    ras_cnt_t count_q;

    ras_ptr_t push_ptr;
    ras_ptr_t pop_ptr;
    logic     full;

    // pointers wrap at the stack depth
    assign push_ptr = top_q + 1'b1;
    assign pop_ptr  = top_q - 1'b1;
    assign full     = (count_q == ras_cnt_t'(RAS_DEPTH));

    always_ff @(posedge CLK) begin
        if (reset) begin
            top_q   <= '0;
            count_q <= '0;
        end else if (push_valid) begin
            top_q <= push_ptr;
            // count holds at 8 on overflow
            if (!full) begin
                count_q <= count_q + 1'b1;
            end
        end else if (pop_valid) begin
            top_q   <= pop_ptr;
            count_q <= count_q - 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge CLK) begin
        if (push_valid) begin
            stack[push_ptr] <= push_pc;
        end
    end

    assign top_pc = stack[top_q];
    assign empty  = (count_q == '0);

    ////////////////////////////////////////
    // checks

    // one instruction is either call or return
    a_no_push_pop: assert property (@(posedge CLK) disable iff (reset)
        !(push_valid && pop_valid));

    // fetch gates pop by empty
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset)
        pop_valid |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
////////////////////////////////////////
// branch predicting fetch front end
// REQ reads btb and pht, RESP picks the
// next pc and emits one fetch per cycle
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  logic           CLK,
    input  logic           reset,

    // restart from ROB
    input  logic           restart_valid,
    input  pc_t            restart_pc,

    // decode puts fetch back to sleep
    input  logic           decode_wait,

    // branch training from execute
    input  logic           update_valid,
    input  branch_update_t update,

    // fetch strobe
    output logic           fetch_valid,
    output fetch_out_t     fetch
);

    ////////////////////////////////////////
    // pipeline state

    // set out of reset, cleared only by restart
    logic wait_state;

    logic req_valid_q;
    pc_t  req_pc_q;
    logic resp_valid_q;
    pc_t  resp_pc_q;

    logic req_advance;
    logic req_valid_d;
    pc_t  req_pc_d;
    pc_t  resp_pc_plus4;

    // child responses
    logic     btb_hit;
    br_type_t btb_hit_type;
    pc_t      btb_hit_target;
    logic     pht_taken;
    pc_t      ras_top_pc;
    logic     ras_empty;

    // RESP decisions
    logic pred_taken;
    pc_t  pred_next_pc;
    logic push_valid;
    logic pop_valid;

    ////////////////////////////////////////
    // predictor tables

    btb btb_inst (
        .CLK          (CLK),
        .reset        (reset),
        .read_valid   (req_advance),
        .read_pc      (req_pc_q),
        .hit          (btb_hit),
        .hit_type     (btb_hit_type),
        .hit_target   (btb_hit_target),
        .update_valid (update_valid),
        .update       (update)
    );

    pht pht_inst (
        .CLK          (CLK),
        .reset        (reset),
        .read_valid   (req_advance),
        .read_pc      (req_pc_q),
        .taken        (pht_taken),
        .update_valid (update_valid),
        .update       (update)
    );

    ras ras_inst (
        .CLK        (CLK),
        .reset      (reset),
        .push_valid (push_valid),
        .push_pc    (resp_pc_plus4),
        .pop_valid  (pop_valid),
        .top_pc     (ras_top_pc),
        .empty      (ras_empty)
    );

    ////////////////////////////////////////
    // RESP prediction

    assign resp_pc_plus4 = resp_pc_q + PC_W'(4);

    always_comb begin
        pred_taken   = 1'b0;
        pred_next_pc = resp_pc_plus4;
        push_valid   = 1'b0;
        pop_valid    = 1'b0;
        // misses fall through to pc + 4
        if (resp_valid_q && btb_hit) begin
            case (btb_hit_type)
                BR_JUMP: begin
                    pred_taken   = 1'b1;
                    pred_next_pc = btb_hit_target;
                end
                BR_CALL: begin
                    pred_taken   = 1'b1;
                    pred_next_pc = btb_hit_target;
                    push_valid   = 1'b1;
                end
                BR_COND: begin
                    if (pht_taken) begin
                        pred_taken   = 1'b1;
                        pred_next_pc = btb_hit_target;
                    end
                end
                BR_RET: begin
                    // empty stack means no prediction
                    if (!ras_empty) begin
                        pred_taken   = 1'b1;
                        pred_next_pc = ras_top_pc;
                        pop_valid    = 1'b1;
                    end
                end
            endcase
        end
    end

    assign fetch_valid        = resp_valid_q;
    assign fetch.pc           = resp_pc_q;
    assign fetch.next_pc      = pred_next_pc;
    assign fetch.pred_taken   = pred_taken;

    ////////////////////////////////////////
    // next REQ pc

    // REQ item survives into RESP only when awake and nothing redirects
    assign req_advance = req_valid_q && !wait_state && !pred_taken
                         && !restart_valid && !decode_wait;

    always_comb begin
        req_valid_d = req_valid_q;
        req_pc_d    = req_pc_q + PC_W'(4);
        if (restart_valid) begin
            req_valid_d = 1'b1;
            req_pc_d    = restart_pc;
        end else if (decode_wait) begin
            req_valid_d = 1'b0;
        end else if (pred_taken) begin
            // drop the item behind the branch
            req_valid_d = 1'b1;
            req_pc_d    = pred_next_pc;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wait_state   <= 1'b1;
            req_valid_q  <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            req_valid_q  <= req_valid_d;
            resp_valid_q <= req_advance;
            if (restart_valid) begin
                wait_state <= 1'b0;
            end else if (decode_wait) begin
                wait_state <= 1'b1;
            end
        end
    end

    // pc moves from REQ to RESP every cycle
    always_ff @(posedge CLK) begin
        req_pc_q  <= req_pc_d;
        resp_pc_q <= req_pc_q;
    end

    // no fetch leaks out while waiting for restart
    a_quiet_in_wait: assert property (@(posedge CLK) disable iff (reset)
        wait_state |-> !fetch_valid);

endmodule

`default_nettype wire

// ==== sim/fetch_unit_tb.sv ====
////////////////////////////////////////
// fetch unit testbench
// table-driven scenarios, a reference
// model of btb, pht and ras, and a check
// of every cycle's fetch strobe
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb
    import fetch_pkg::*;
();

    typedef enum logic [1:0] {
        STEP_UPDATE,
        STEP_RESTART,
        STEP_WAIT,
        STEP_OBSERVE
    } step_kind_t;

    // DUT connections
    logic           CLK = 1'b0;
    logic           reset;
    logic           restart_valid;
    pc_t            restart_pc;
    logic           decode_wait;
    logic           update_valid;
    branch_update_t update;
    logic           fetch_valid;
    fetch_out_t     fetch;

    // scenario table, one entry per step
    string      step_name   [$];
    step_kind_t step_kind   [$];
    pc_t        step_pc     [$];
    pc_t        step_target [$];
    br_type_t   step_type   [$];
    logic       step_taken  [$];
    int         step_cycles [$];

    ////////////////////////////////////////
    // reference model state

    logic                 m_btb_valid  [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] m_btb_tag    [BTB_ENTRIES];
    br_type_t             m_btb_type   [BTB_ENTRIES];
    pc_t                  m_btb_target [BTB_ENTRIES];
    logic [1:0]           m_ctr        [PHT_ENTRIES];
    ghr_t                 m_ghr;
    pc_t                  m_ras        [RAS_DEPTH];
    int                   m_ras_top;
    int                   m_ras_count;

    // expected stream: running flag, next pc, empty cycles before it
    bit  m_active;
    pc_t m_pc;
    int  m_gap;

    // an update lands in the model one cycle after it is driven
    bit             upd_pending;
    branch_update_t pending_update;

    integer seed        = 32'he331;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    int     errors      = 0;
    int     checks      = 0;
    int     strobes     = 0;
    string  cur_name    = "reset";

    fetch_unit fetch_unit_inst (
        .CLK           (CLK),
        .reset         (reset),
        .restart_valid (restart_valid),
        .restart_pc    (restart_pc),
        .decode_wait   (decode_wait),
        .update_valid  (update_valid),
        .update        (update),
        .fetch_valid   (fetch_valid),
        .fetch         (fetch)
    );

    always #10 CLK = ~CLK;

    // cycle limit guard
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: scenario table still running after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // gap after a wait, 3 to 10 cycles
    function automatic int random_gap();
        random_gap = 3 + ($unsigned($random(seed)) % 8);
    endfunction

    task automatic add_step(input string name, input step_kind_t kind, input pc_t pc,
                            input pc_t target, input br_type_t br_type, input logic taken,
                            input int cycles);
        step_name.push_back(name);
        step_kind.push_back(kind);
        step_pc.push_back(pc);
        step_target.push_back(target);
        step_type.push_back(br_type);
        step_taken.push_back(taken);
        step_cycles.push_back(cycles);
    endtask

    ////////////////////////////////////////
    // model rules

    // prediction for one fetched pc, read off the model tables
    task automatic predict(input pc_t pc, output pc_t next_pc, output logic taken,
                           output logic push, output logic pop);
        logic [BTB_IDX_W-1:0] bi;
        logic [PHT_IDX_W-1:0] pi;
        bi      = pc[BTB_IDX_W+1:2];
        pi      = pc[PHT_IDX_W+1:2] ^ m_ghr;
        next_pc = pc + 4;
        taken   = 1'b0;
        push    = 1'b0;
        pop     = 1'b0;
        if (m_btb_valid[bi] && m_btb_tag[bi] == pc[PC_W-1:BTB_IDX_W+2]) begin
            case (m_btb_type[bi])
                BR_JUMP: begin
                    next_pc = m_btb_target[bi];
                    taken   = 1'b1;
                end
                BR_CALL: begin
                    next_pc = m_btb_target[bi];
                    taken   = 1'b1;
                    push    = 1'b1;
                end
                BR_COND: begin
                    // counter 2 or 3 means taken
                    if (m_ctr[pi] >= 2'd2) begin
                        next_pc = m_btb_target[bi];
                        taken   = 1'b1;
                    end
                end
                BR_RET: begin
                    if (m_ras_count > 0) begin
                        next_pc = m_ras[m_ras_top];
                        taken   = 1'b1;
                        pop     = 1'b1;
                    end
                end
            endcase
        end
    endtask

    task automatic apply_update(input branch_update_t u);
        logic [BTB_IDX_W-1:0] bi;
        logic [PHT_IDX_W-1:0] pi;
        bi = u.pc[BTB_IDX_W+1:2];
        pi = u.pc[PHT_IDX_W+1:2] ^ m_ghr;
        // not-taken cond branches do not allocate
        if (u.taken || u.br_type != BR_COND) begin
            m_btb_valid[bi]  = 1'b1;
            m_btb_tag[bi]    = u.pc[PC_W-1:BTB_IDX_W+2];
            m_btb_type[bi]   = u.br_type;
            m_btb_target[bi] = u.target;
        end
        if (u.br_type == BR_COND) begin
            if (u.taken && m_ctr[pi] != 2'd3) begin
                m_ctr[pi] = m_ctr[pi] + 2'd1;
            end else if (!u.taken && m_ctr[pi] != 2'd0) begin
                m_ctr[pi] = m_ctr[pi] - 2'd1;
            end
            m_ghr = {m_ghr[GHR_W-2:0], u.taken};
        end
    endtask

    ////////////////////////////////////////
    // per-cycle check, before inputs move

    task automatic check_cycle();
        pc_t  exp_next;
        logic exp_taken;
        logic do_push;
        logic do_pop;
        if (fetch_valid) begin
            strobes++;
        end
        if (m_active && m_gap == 0) begin
            predict(m_pc, exp_next, exp_taken, do_push, do_pop);
            checks++;
            if (!fetch_valid) begin
                $display("%s: no fetch strobe where one for pc %h was due", cur_name, m_pc);
                errors++;
            end else begin
                if (fetch.pc != m_pc) begin
                    $display("ERROR %s pc: expected %h actual %h", cur_name, m_pc, fetch.pc);
                    errors++;
                end
                if (fetch.next_pc != exp_next) begin
                    $display("ERROR %s next_pc: expected %h actual %h",
                             cur_name, exp_next, fetch.next_pc);
                    errors++;
                end
                if (fetch.pred_taken != exp_taken) begin
                    $display("ERROR %s pred_taken: expected %0b actual %0b",
                             cur_name, exp_taken, fetch.pred_taken);
                    errors++;
                end
            end
            // model ras follows the same wrap and saturation rule
            if (do_push) begin
                m_ras_top         = (m_ras_top + 1) % RAS_DEPTH;
                m_ras[m_ras_top]  = m_pc + 4;
                if (m_ras_count < RAS_DEPTH) begin
                    m_ras_count++;
                end
            end
            if (do_pop) begin
                m_ras_top = (m_ras_top + RAS_DEPTH - 1) % RAS_DEPTH;
                m_ras_count--;
            end
            m_pc  = exp_next;
            m_gap = exp_taken ? 1 : 0;
        end else begin
            if (m_gap > 0) begin
                m_gap--;
            end
            if (fetch_valid) begin
                $display("%s: fetch strobe for pc %h came when none was due",
                         cur_name, fetch.pc);
                errors++;
            end
        end
    endtask

    task automatic drive_step(input int r);
        case (step_kind[r])
            STEP_UPDATE: begin
                update_valid   = 1'b1;
                update.pc      = step_pc[r];
                update.target  = step_target[r];
                update.br_type = step_type[r];
                update.taken   = step_taken[r];
                pending_update = update;
                upd_pending    = 1'b1;
            end
            STEP_RESTART: begin
                // one empty cycle, then the restart pc
                restart_valid = 1'b1;
                restart_pc    = step_pc[r];
                m_active      = 1'b1;
                m_pc          = step_pc[r];
                m_gap         = 1;
            end
            STEP_WAIT: begin
                decode_wait = 1'b1;
                m_active    = 1'b0;
                m_gap       = 0;
            end
            default: begin
            end
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        reset         = 1'b1;
        restart_valid = 1'b0;
        restart_pc    = '0;
        decode_wait   = 1'b0;
        update_valid  = 1'b0;
        update        = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_ctr[i] = 2'b01;
        end
        m_ghr       = '0;
        m_ras_top   = 0;
        m_ras_count = 0;
        m_active    = 1'b0;
        m_pc        = '0;
        m_gap       = 0;
        upd_pending = 1'b0;

        // name, kind, pc, target, type, taken, cycles
        add_step("reset_idle",    STEP_OBSERVE, 32'h0, 32'h0, BR_COND, 1'b0, 4);
        add_step("seq_restart",   STEP_RESTART, 32'h1000, 32'h0, BR_COND, 1'b0, 8);
        add_step("seq_wait",      STEP_WAIT,    32'h0, 32'h0, BR_COND, 1'b0, random_gap());
        add_step("jump_train",    STEP_UPDATE,  32'h2008, 32'h2400, BR_JUMP, 1'b1, 2);
        add_step("jump_run",      STEP_RESTART, 32'h2000, 32'h0, BR_COND, 1'b0, 10);
        add_step("jump_wait",     STEP_WAIT,    32'h0, 32'h0, BR_COND, 1'b0, random_gap());
        add_step("cond_train_a",  STEP_UPDATE,  32'h301c, 32'h3100, BR_COND, 1'b1, 2);
        add_step("cond_run_a",    STEP_RESTART, 32'h3018, 32'h0, BR_COND, 1'b0, 6);
        add_step("cond_wait_a",   STEP_WAIT,    32'h0, 32'h0, BR_COND, 1'b0, random_gap());
        add_step("cond_train_b",  STEP_UPDATE,  32'h3010, 32'h3100, BR_COND, 1'b1, 2);
        add_step("cond_run_b",    STEP_RESTART, 32'h3008, 32'h0, BR_COND, 1'b0, 9);
        add_step("cond_wait_b",   STEP_WAIT,    32'h0, 32'h0, BR_COND, 1'b0, random_gap());
        add_step("call_train",    STEP_UPDATE,  32'h4004, 32'h4200, BR_CALL, 1'b1, 1);
        add_step("ret_train",     STEP_UPDATE,  32'h4208, 32'h0, BR_RET, 1'b1, 2);
        add_step("call_ret_run",  STEP_RESTART, 32'h4000, 32'h0, BR_COND, 1'b0, 14);
        add_step("call_ret_wait", STEP_WAIT,    32'h0, 32'h0, BR_COND, 1'b0, random_gap());
        add_step("ret_empty_run", STEP_RESTART, 32'h4208, 32'h0, BR_COND, 1'b0, 6);
        add_step("restart_mid",   STEP_RESTART, 32'h5000, 32'h0, BR_COND, 1'b0, 6);
        add_step("end_wait",      STEP_WAIT,    32'h0, 32'h0, BR_COND, 1'b0, random_gap());
        add_step("end_idle",      STEP_OBSERVE, 32'h0, 32'h0, BR_COND, 1'b0, 4);

        cycle_limit = 50;
        foreach (step_cycles[r]) begin
            cycle_limit += step_cycles[r];
        end

        repeat (4) @(negedge CLK);
        reset = 1'b0;

        for (int r = 0; r < step_name.size(); r++) begin
            cur_name = step_name[r];
            for (int k = 0; k < step_cycles[r]; k++) begin
                @(negedge CLK);
                check_cycle();
                if (upd_pending) begin
                    apply_update(pending_update);
                    upd_pending = 1'b0;
                end
                restart_valid = 1'b0;
                decode_wait   = 1'b0;
                update_valid  = 1'b0;
                if (k == 0) begin
                    drive_step(r);
                end
            end
        end

        $display("checks %0d, strobes %0d, errors %0d", checks, strobes, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/fetch_pkg.sv
rtl/btb.sv
rtl/pht.sv
rtl/ras.sv
rtl/fetch_unit.sv
sim/fetch_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the fetch unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_unit_tb -o fetch_unit_sim -f sim.f || exit 1

out=$(./obj_dir/fetch_unit_sim)
echo "$out"
echo "$out" | grep -q "^SIMULATION PASSED$" && exit 0 || exit 1
